//--- common/uart_pkg.sv
`default_nettype none

package uart_pkg;

  localparam int bit_cycles   = 434;  // 50 MHz clock, 115200 baud.
  localparam int gap_bits     = 16;   // idle bit-times between write frames.
  localparam int timeout_bits = 64;   // reply start bit deadline.

  localparam int cmd_width  = 16;
  localparam int data_width = 8;
  localparam int addr_width = 7;
  localparam int cmd_rw_bit = 15;     // 1 = write, 0 = read.

  localparam int frame_bits = data_width + 3;  // start, data, parity, stop.
  localparam int idx_width  = $clog2(frame_bits);

  localparam int bit_cnt_width  = $clog2(bit_cycles);
  localparam int wait_cnt_width = $clog2(timeout_bits * bit_cycles);

  typedef enum logic [2:0] {
    idle,
    send_addr,
    wait_addr,
    gap,
    send_data,
    wait_data,
    wait_reply,
    finish
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- files.f
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_cmd_ctrl.sv
verilog/cmd_arbiter.sv
verilog/uart_cmd_bridge.sv
tests/tb_uart_cmd_bridge.sv

//--- tests/tb_uart_cmd_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_cmd_bridge;
  import uart_pkg::*;

  localparam int n_cmds      = 30;  // per port.
  localparam int cycle_limit = 2 * n_cmds * 120 * bit_cycles;

  logic                clk;
  logic                rst_n;
  logic [1:0][15:0]    cmd_in;
  logic [1:0]          cmd_vld;
  wire  [1:0]          cmd_rdy;
  wire  [1:0]          read_rdy;
  wire  [1:0]          read_err;
  wire  [1:0][7:0]     read_data;
  logic                rx;
  wire                 tx;

  integer              seed = 32'h78514e37;
  int                  cycles = 0;
  int                  seen_cnt = 0;
  logic [16:0]         acc_q [$];  // {port, command} in acceptance order.
  logic [9:0]          exp_q [$];  // {port, err, data} per read.
  logic [7:0]          regs [0:127];
  logic                last_grant = 1'b0;
  logic                granted_once = 1'b0;

  uart_cmd_bridge i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in_0    (cmd_in[0]),
    .cmd_vld_0   (cmd_vld[0]),
    .cmd_rdy_0   (cmd_rdy[0]),
    .read_rdy_0  (read_rdy[0]),
    .read_data_0 (read_data[0]),
    .read_err_0  (read_err[0]),
    .cmd_in_1    (cmd_in[1]),
    .cmd_vld_1   (cmd_vld[1]),
    .cmd_rdy_1   (cmd_rdy[1]),
    .read_rdy_1  (read_rdy[1]),
    .read_data_1 (read_data[1]),
    .read_err_1  (read_err[1]),
    .rx          (rx),
    .tx          (tx)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual)
      fail_run($sformatf("ERR %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  task automatic check_quiet_outputs(input string name);
    compare({name, " tx"}, 1, tx);
    compare({name, " handshake outputs"}, 0, {cmd_rdy, read_rdy, read_err});
  endtask

  // decode one frame on tx, sampled at bit centers.
  task automatic recv_frame(output logic [7:0] b);
    int i;
    while (tx !== 1'b0)
      @(negedge clk);
    repeat (bit_cycles / 2) @(negedge clk);
    compare("start bit", 0, tx);
    for (i = 0; i < 8; i++)
    begin
      repeat (bit_cycles) @(negedge clk);
      b[i] = tx;  // lsb first.
    end
    repeat (bit_cycles) @(negedge clk);
    compare("parity bit", ^b, tx);
    repeat (bit_cycles) @(negedge clk);
    compare("stop bit", 1, tx);
  endtask

  task automatic drive_bit(input logic v);
    rx = v;
    repeat (bit_cycles) @(negedge clk);
  endtask

  task automatic send_reply(input logic [7:0] b, input logic bad, input int delay);
    int i;
    repeat (delay * bit_cycles) @(negedge clk);
    drive_bit(1'b0);
    for (i = 0; i < 8; i++)
      drive_bit(b[i]);
    drive_bit(^b ^ bad);
    drive_bit(1'b1);
  endtask

  task automatic run_requester(input int p);
    logic [15:0] cmd;
    int          k;
    int          r;
    @(negedge clk);
    for (k = 0; k < n_cmds; k++)
    begin
      r = $random(seed);
      repeat (r[29:24]) @(negedge clk);
      cmd[15]   = r[0];
      cmd[14:8] = r[1] ? r[8:2] : {3'b000, r[5:2]};  // favor a few addresses.
      cmd[7:0]  = r[0] ? r[23:16] : 8'h00;
      cmd_in[p]  = cmd;
      cmd_vld[p] = 1'b1;
      @(posedge clk);
      while (!cmd_rdy[p])
        @(posedge clk);
      acc_q.push_back({p[0], cmd});
      @(negedge clk);
      cmd_vld[p] = 1'b0;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
      fail_run("timeout: the run did not complete within the cycle limit");
  end

  always @(posedge clk)
  begin : grant_monitor
    if (rst_n && cmd_rdy != 2'b00)
    begin
      compare("one grant per cycle", 0, cmd_rdy == 2'b11);
      if (cmd_vld == 2'b11 && granted_once)
        compare("round robin grant", !last_grant, cmd_rdy[1]);
      granted_once = 1'b1;
      last_grant   = cmd_rdy[1];
    end
  end

  always @(posedge clk)
  begin : read_monitor
    int         p;
    logic [9:0] got;
    if (rst_n)
      for (p = 0; p < 2; p++)
        if (read_rdy[p] || read_err[p])
        begin
          if (exp_q.size() == 0)
            fail_run($sformatf("port %0d returned a read result with no read pending", p));
          else
          begin
            compare("read_rdy with read_err", 0, read_rdy[p] && read_err[p]);
            got = {p[0], read_err[p], read_err[p] ? 8'h00 : read_data[p]};
            compare($sformatf("read result port %0d", p), exp_q.pop_front(), got);
          end
        end
  end

  // remote register device on tx/rx.
  initial
  begin : device_model
    logic [7:0]  first;
    logic [7:0]  second;
    logic [7:0]  reply;
    logic [16:0] acc;
    int          idle;
    int          i;
    int          r;
    int          delay;
    for (i = 0; i < 128; i++)
      regs[i] = 8'h00;
    forever
    begin
      recv_frame(first);
      if (acc_q.size() == 0)
        fail_run("a frame appeared on tx with no accepted command");
      else
      begin
        acc = acc_q.pop_front();
        if (first[7])
        begin
          idle = 0;
          while (tx !== 1'b0)
          begin
            @(negedge clk);
            idle++;
          end
          compare("write gap", 1, idle >= gap_bits * bit_cycles + bit_cycles / 2);
          recv_frame(second);
          compare($sformatf("write command port %0d", acc[16]), acc[15:0], {first, second});
          regs[first[6:0]] = second;
        end
        else
        begin
          compare($sformatf("read command port %0d", acc[16]), acc[15:0], {first, 8'h00});
          r     = $random(seed);
          delay = 1 + r[15:8] % 20;
          reply = regs[first[6:0]];
          if (r[2:0] == 3'd0)
            exp_q.push_back({acc[16], 1'b1, 8'h00});  // no reply.
          else if (r[2:0] == 3'd1)
          begin
            exp_q.push_back({acc[16], 1'b1, 8'h00});
            fork
              send_reply(reply, 1'b1, delay);
            join_none
          end
          else
          begin
            exp_q.push_back({acc[16], 1'b0, reply});
            fork
              send_reply(reply, 1'b0, delay);
            join_none
          end
        end
        seen_cnt++;
      end
    end
  end

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 2'b00;
    rx      = 1'b1;
    repeat (10)
    begin
      @(negedge clk);
      check_quiet_outputs("reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_quiet_outputs("after reset");
    fork
      run_requester(0);
      run_requester(1);
    join
    while (seen_cnt < 2 * n_cmds || exp_q.size() != 0)
      @(posedge clk);
    repeat (2 * bit_cycles)
    begin
      @(negedge clk);
      compare("tx idle after last command", 1, tx);  // no stray frame.
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart/uart_cmd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_ctrl (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire  [uart_pkg::cmd_width-1:0]  arb_cmd,
  input  wire                             arb_vld,
  output logic                            ctrl_rdy,
  output logic                            tx_start,
  output logic [uart_pkg::data_width-1:0] tx_byte,
  input  wire                             tx_done,
  input  wire                             rx_valid,
  input  wire  [uart_pkg::data_width-1:0] rx_byte,
  input  wire                             rx_bad,
  input  wire                             rx_busy,
  output logic                            rd_done,
  output logic                            rd_err,
  output logic [uart_pkg::data_width-1:0] rd_data
);
  import uart_pkg::*;

  ctrl_state_e               state_q;
  ctrl_state_e               state_d;
  logic [cmd_width-1:0]      cmd_q;
  logic [data_width-1:0]     data_q;
  logic [wait_cnt_width-1:0] wait_q;  // gap and reply timeout.
  logic                      err_q;
  logic                      gap_end;
  logic                      timeout;

  assign gap_end = wait_q == wait_cnt_width'(gap_bits * bit_cycles - 1);
  assign timeout = wait_q == wait_cnt_width'(timeout_bits * bit_cycles - 1);

  assign ctrl_rdy = state_q == idle;
  assign tx_start = (state_q == send_addr) || (state_q == send_data);
  assign tx_byte  = (state_q == send_data) ? cmd_q[data_width-1:0]
                                           : {cmd_q[cmd_rw_bit], cmd_q[data_width +: addr_width]};
  assign rd_done  = (state_q == finish) && !err_q;
  assign rd_err   = (state_q == finish) && err_q;
  assign rd_data  = data_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      idle:
        if (arb_vld)
          state_d = send_addr;
      send_addr:
        state_d = wait_addr;
      wait_addr:
        if (tx_done)
          state_d = cmd_q[cmd_rw_bit] ? gap : wait_reply;
      gap:
        if (gap_end)
          state_d = send_data;
      send_data:
        state_d = wait_data;
      wait_data:
        if (tx_done)
          state_d = idle;
      wait_reply:
      begin
        // a started frame holds off the timeout.
        if (rx_valid)
          state_d = finish;
        else if (!rx_busy && timeout)
          state_d = finish;
      end
      finish:
        state_d = idle;
      default:
        state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= idle;
      wait_q  <= '0;
      err_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q != state_d)
        wait_q <= '0;
      else if (state_q == gap || (state_q == wait_reply && !rx_busy))
        wait_q <= wait_q + 1'b1;
      if (state_q == wait_reply)
        err_q <= !rx_valid || rx_bad;  // timeout or bad frame.
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == idle && arb_vld)
      cmd_q <= arb_cmd;
    if (state_q == wait_reply && rx_valid)
      data_q <= rx_byte;
  end

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             rx,
  output logic                            rx_valid,
  output logic [uart_pkg::data_width-1:0] rx_byte,
  output logic                            rx_bad,
  output logic                            rx_busy
);
  import uart_pkg::*;

  logic                     rx_meta_q;
  logic                     rx_sync_q;
  logic                     rx_prev_q;
  logic                     busy_q;
  logic                     start_q;  // confirming start bit.
  logic [bit_cnt_width-1:0] cnt_q;
  logic [idx_width-1:0]     idx_q;
  logic [data_width-1:0]    data_q;
  logic                     par_q;
  logic                     valid_q;
  logic                     bad_q;

  assign rx_valid = valid_q;
  assign rx_bad   = bad_q;
  assign rx_byte  = data_q;
  assign rx_busy  = busy_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      busy_q    <= 1'b0;
      start_q   <= 1'b0;
      cnt_q     <= '0;
      idx_q     <= '0;
      valid_q   <= 1'b0;
      bad_q     <= 1'b0;
    end
    else
    begin
      rx_meta_q <= rx;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      valid_q   <= 1'b0;
      if (!busy_q)
      begin
        if (rx_prev_q && !rx_sync_q)
        begin
          busy_q  <= 1'b1;
          start_q <= 1'b1;
          cnt_q   <= '0;
          idx_q   <= '0;
        end
      end
      else if (start_q)
      begin
        if (cnt_q == bit_cnt_width'(bit_cycles / 2 - 1))
        begin
          cnt_q   <= '0;
          start_q <= 1'b0;
          busy_q  <= !rx_sync_q;  // glitch, not a start bit.
        end
        else
        begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
      else if (cnt_q == bit_cnt_width'(bit_cycles - 1))
      begin
        // bit center reached.
        cnt_q <= '0;
        idx_q <= idx_q + 1'b1;
        if (idx_q == idx_width'(data_width + 1))
        begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
          bad_q   <= (^data_q ^ par_q) | !rx_sync_q;
        end
      end
      else
      begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // payload capture.
  always_ff @(posedge clk)
  begin
    if (busy_q && !start_q && cnt_q == bit_cnt_width'(bit_cycles - 1))
    begin
      if (idx_q < idx_width'(data_width))
        data_q <= {rx_sync_q, data_q[data_width-1:1]};  // lsb first.
      else if (idx_q == idx_width'(data_width))
        par_q <= rx_sync_q;
    end
  end

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             tx_start,
  input  wire  [uart_pkg::data_width-1:0] tx_byte,
  output logic                            tx,
  output logic                            tx_done
);
  import uart_pkg::*;

  logic [frame_bits-1:0]    shift_q;
  logic [bit_cnt_width-1:0] cnt_q;
  logic [idx_width-1:0]     idx_q;
  logic                     busy_q;
  logic                     bit_end;

  assign bit_end = busy_q && (cnt_q == bit_cnt_width'(bit_cycles - 1));
  assign tx_done = bit_end && (idx_q == idx_width'(frame_bits - 1));
  assign tx      = shift_q[0];  // all ones when idle.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '1;
      cnt_q   <= '0;
      idx_q   <= '0;
      busy_q  <= 1'b0;
    end
    else if (tx_start && !busy_q)
    begin
      // start cycle counts as the first cycle of the start bit
      busy_q  <= 1'b1;
      cnt_q   <= bit_cnt_width'(1);
      idx_q   <= '0;
      shift_q <= {1'b1, ^tx_byte, tx_byte, 1'b0};  // even parity.
    end
    else if (busy_q)
    begin
      if (bit_end)
      begin
        cnt_q   <= '0;
        shift_q <= {1'b1, shift_q[frame_bits-1:1]};
        if (idx_q == idx_width'(frame_bits - 1))
          busy_q <= 1'b0;
        else
          idx_q <= idx_q + 1'b1;
      end
      else
      begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/cmd_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_arbiter (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire  [uart_pkg::cmd_width-1:0]  cmd_in_0,
  input  wire                             cmd_vld_0,
  output logic                            cmd_rdy_0,
  output logic                            read_rdy_0,
  output logic [uart_pkg::data_width-1:0] read_data_0,
  output logic                            read_err_0,
  input  wire  [uart_pkg::cmd_width-1:0]  cmd_in_1,
  input  wire                             cmd_vld_1,
  output logic                            cmd_rdy_1,
  output logic                            read_rdy_1,
  output logic [uart_pkg::data_width-1:0] read_data_1,
  output logic                            read_err_1,
  output logic [uart_pkg::cmd_width-1:0]  arb_cmd,
  output logic                            arb_vld,
  input  wire                             ctrl_rdy,
  input  wire                             rd_done,
  input  wire                             rd_err,
  input  wire  [uart_pkg::data_width-1:0] rd_data
);
  import uart_pkg::*;

  logic owner_q;  // last granted port, also owner of the read in flight.
  logic sel;
  logic accept;

  // with both ports waiting, the port not granted last goes first
  assign sel    = (cmd_vld_0 && cmd_vld_1) ? !owner_q : cmd_vld_1;
  assign arb_vld = cmd_vld_0 || cmd_vld_1;
  assign arb_cmd = sel ? cmd_in_1 : cmd_in_0;
  assign accept  = arb_vld && ctrl_rdy;

  assign cmd_rdy_0 = accept && !sel;
  assign cmd_rdy_1 = accept && sel;

  assign read_rdy_0  = rd_done && !owner_q;
  assign read_err_0  = rd_err && !owner_q;
  assign read_data_0 = rd_data;
  assign read_rdy_1  = rd_done && owner_q;
  assign read_err_1  = rd_err && owner_q;
  assign read_data_1 = rd_data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      owner_q <= 1'b0;
    else if (accept)
      owner_q <= sel;
  end

endmodule

`default_nettype wire

//--- verilog/uart_cmd_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_bridge (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire  [uart_pkg::cmd_width-1:0]  cmd_in_0,
  input  wire                             cmd_vld_0,
  output wire                             cmd_rdy_0,
  output wire                             read_rdy_0,
  output wire  [uart_pkg::data_width-1:0] read_data_0,
  output wire                             read_err_0,
  input  wire  [uart_pkg::cmd_width-1:0]  cmd_in_1,
  input  wire                             cmd_vld_1,
  output wire                             cmd_rdy_1,
  output wire                             read_rdy_1,
  output wire  [uart_pkg::data_width-1:0] read_data_1,
  output wire                             read_err_1,
  input  wire                             rx,
  output wire                             tx
);
  import uart_pkg::*;

  wire [cmd_width-1:0]  arb_cmd;
  wire                  arb_vld;
  wire                  ctrl_rdy;
  wire                  rd_done;
  wire                  rd_err;
  wire [data_width-1:0] rd_data;
  wire                  tx_start;
  wire [data_width-1:0] tx_byte;
  wire                  tx_done;
  wire                  rx_valid;
  wire [data_width-1:0] rx_byte;
  wire                  rx_bad;
  wire                  rx_busy;

  cmd_arbiter i_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in_0    (cmd_in_0),
    .cmd_vld_0   (cmd_vld_0),
    .cmd_rdy_0   (cmd_rdy_0),
    .read_rdy_0  (read_rdy_0),
    .read_data_0 (read_data_0),
    .read_err_0  (read_err_0),
    .cmd_in_1    (cmd_in_1),
    .cmd_vld_1   (cmd_vld_1),
    .cmd_rdy_1   (cmd_rdy_1),
    .read_rdy_1  (read_rdy_1),
    .read_data_1 (read_data_1),
    .read_err_1  (read_err_1),
    .arb_cmd     (arb_cmd),
    .arb_vld     (arb_vld),
    .ctrl_rdy    (ctrl_rdy),
    .rd_done     (rd_done),
    .rd_err      (rd_err),
    .rd_data     (rd_data)
  );

  uart_cmd_ctrl i_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_cmd  (arb_cmd),
    .arb_vld  (arb_vld),
    .ctrl_rdy (ctrl_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_bad   (rx_bad),
    .rx_busy  (rx_busy),
    .rd_done  (rd_done),
    .rd_err   (rd_err),
    .rd_data  (rd_data)
  );

  uart_tx i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx i_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_bad   (rx_bad),
    .rx_busy  (rx_busy)
  );

endmodule

`default_nettype wire
